// ==== mem_ctrl_config.svh ====
// address, ram depth and size code macros shared by the memory controller rtl and testbench
`ifndef MEM_CTRL_CONFIG_SVH
`define MEM_CTRL_CONFIG_SVH

// byte address width seen by both clients
`define MEM_ADDR_W 32

// bytes in the on-chip ram, only the low address bits index it
`define MEM_RAM_DEPTH 1024

// access size codes, also used when parsing stimulus
`define MEM_SIZE_B 0
`define MEM_SIZE_H 1
`define MEM_SIZE_W 2

`endif

// ==== mem_ctrl_pkg.sv ====
// access size enum and word/byte union, imported by the memory controller modules
`default_nettype none

`include "mem_ctrl_config.svh"

package mem_ctrl_pkg;

    // encodings follow the size codes from the config header
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'(`MEM_SIZE_B),
        MEM_SIZE_HALF = 2'(`MEM_SIZE_H),
        MEM_SIZE_WORD = 2'(`MEM_SIZE_W)
    } mem_size_e;

    // one 32-bit word, either whole or as little-endian byte lanes
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  b;
    } word_bytes_u;

endpackage

`default_nettype wire

// ==== byte_ram.sv ====
// byte-wide synchronous ram with registered read, one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_config.svh"

module byte_ram (
    input  wire                     clk,
    input  wire [`MEM_ADDR_W-1:0]   ram_addr_i,
    input  wire                     ram_we_i,
    input  wire [7:0]               ram_wdata_i,
    output logic [7:0]              ram_rdata_o
);

    localparam int AW = $clog2(`MEM_RAM_DEPTH);

    logic [7:0]    mem [`MEM_RAM_DEPTH];
    logic [AW-1:0] index;

    // addresses wrap over the ram depth
    assign index = ram_addr_i[AW-1:0];

    always_ff @(posedge clk) begin
        if (ram_we_i) begin
            mem[index] <= ram_wdata_i;
        end
        ram_rdata_o <= mem[index];
    end

endmodule

`default_nettype wire

// ==== mem_req_decode.sv ====
// request stage of the memory controller: arbitrates fetch and data, latches the winner
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_config.svh"

module mem_req_decode import mem_ctrl_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     if_req_valid_i,
    output logic                    if_req_ready_o,
    input  wire [`MEM_ADDR_W-1:0]   if_addr_i,
    input  wire                     dm_req_valid_i,
    output logic                    dm_req_ready_o,
    input  wire                     dm_we_i,
    input  wire mem_size_e          dm_size_i,
    input  wire [`MEM_ADDR_W-1:0]   dm_addr_i,
    input  wire [31:0]              dm_wdata_i,
    input  wire                     release_i,
    output logic                    start_o,
    output logic                    is_data_o,
    output logic                    we_o,
    output mem_size_e               size_o,
    output logic [2:0]              nbytes_o,
    output logic [`MEM_ADDR_W-1:0]  addr_o,
    output logic [31:0]             wdata_o
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e     state_q;
    logic       dm_accept;
    logic       if_accept;
    logic [2:0] dm_nbytes;

    // data port has priority, fetch only sees ready when data is quiet
    assign dm_req_ready_o = (state_q == ST_IDLE);
    assign if_req_ready_o = (state_q == ST_IDLE) && !dm_req_valid_i;

    assign dm_accept = dm_req_valid_i && dm_req_ready_o;
    assign if_accept = if_req_valid_i && if_req_ready_o;

    always_comb begin
        case (dm_size_i)
            MEM_SIZE_BYTE: dm_nbytes = 3'd1;
            MEM_SIZE_HALF: dm_nbytes = 3'd2;
            default:       dm_nbytes = 3'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            start_o <= 1'b0;
        end else begin
            start_o <= dm_accept || if_accept;
            case (state_q)
                ST_IDLE: if (dm_accept || if_accept) state_q <= ST_BUSY;
                ST_BUSY: if (release_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // fields stay put until the next accept
    always_ff @(posedge clk) begin
        if (dm_accept) begin
            is_data_o <= 1'b1;
            we_o      <= dm_we_i;
            size_o    <= dm_size_i;
            nbytes_o  <= dm_nbytes;
            addr_o    <= dm_addr_i;
            wdata_o   <= dm_wdata_i;
        end else if (if_accept) begin
            is_data_o <= 1'b0;
            we_o      <= 1'b0;
            size_o    <= MEM_SIZE_WORD;
            nbytes_o  <= 3'd4;
            addr_o    <= if_addr_i;
            wdata_o   <= '0;
        end
    end

    // a response handshake only closes an access that is in flight
    a_release_busy: assert property (@(posedge clk) disable iff (reset_i)
        release_i |-> (state_q == ST_BUSY));

endmodule

`default_nettype wire

// ==== mem_byte_sequencer.sv ====
// execute stage of the memory controller: walks the ram one byte per cycle for an access
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_config.svh"

module mem_byte_sequencer import mem_ctrl_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     start_i,
    input  wire                     we_i,
    input  wire [2:0]               nbytes_i,
    input  wire [`MEM_ADDR_W-1:0]   addr_i,
    input  wire [31:0]              wdata_i,
    output logic [`MEM_ADDR_W-1:0]  ram_addr_o,
    output logic                    ram_we_o,
    output logic [7:0]              ram_wdata_o,
    input  wire [7:0]               ram_rdata_i,
    output logic                    done_o,
    output logic [31:0]             load_word_o
);

    logic                   busy_q;
    logic [2:0]             cnt_q;
    logic                   rd_pend_q;
    word_bytes_u            cap_q;
    word_bytes_u            store_w;
    word_bytes_u            load_w;
    logic                   issue;
    logic [2:0]             idx;
    logic [2:0]             lane;

    // byte 0 goes out in the start cycle itself
    assign issue = start_i || (busy_q && (cnt_q < nbytes_i));
    assign idx   = start_i ? 3'd0 : cnt_q;

    assign store_w     = wdata_i;
    assign ram_addr_o  = addr_i + `MEM_ADDR_W'(idx);
    assign ram_we_o    = issue && we_i;
    assign ram_wdata_o = store_w.b[idx[1:0]];

    // returning byte belongs to the lane issued one cycle earlier
    assign lane = cnt_q - 3'd1;

    always_comb begin
        load_w = cap_q;
        if (rd_pend_q) begin
            load_w.b[lane[1:0]] = ram_rdata_i;
        end
    end

    assign load_word_o = load_w;

    // stores finish with the last write, loads with the last returned byte
    assign done_o = (we_i && issue && (idx == nbytes_i - 3'd1))
                 || (!we_i && rd_pend_q && (cnt_q == nbytes_i));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            cnt_q     <= 3'd0;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= issue && !we_i;
            if (done_o) begin
                busy_q <= 1'b0;
                cnt_q  <= 3'd0;
            end else if (issue) begin
                busy_q <= 1'b1;
                cnt_q  <= idx + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            cap_q <= load_w;
        end
    end

    a_cnt_bound: assert property (@(posedge clk) disable iff (reset_i)
        busy_q |-> (cnt_q <= nbytes_i));

endmodule

`default_nettype wire

// ==== mem_load_assemble.sv ====
// result stage of the memory controller: masks load data and holds the client response
`timescale 1ns/1ps
`default_nettype none

module mem_load_assemble import mem_ctrl_pkg::*; (
    input  wire         clk,
    input  wire         reset_i,
    input  wire         done_i,
    input  wire         is_data_i,
    input  wire         we_i,
    input  wire mem_size_e size_i,
    input  wire [31:0]  load_word_i,
    output logic        release_o,
    output logic        if_resp_valid_o,
    input  wire         if_resp_ready_i,
    output logic [31:0] if_inst_o,
    output logic        dm_resp_valid_o,
    input  wire         dm_resp_ready_i,
    output logic [31:0] dm_rdata_o
);

    word_bytes_u raw;
    word_bytes_u masked;

    assign raw = load_word_i;

    // zero-extend by keeping only the lanes the size covers, stores return zero
    always_comb begin
        masked = '0;
        if (!we_i) begin
            masked.b[0] = raw.b[0];
            if (size_i != MEM_SIZE_BYTE) begin
                masked.b[1] = raw.b[1];
            end
            if (size_i == MEM_SIZE_WORD) begin
                masked.b[2] = raw.b[2];
                masked.b[3] = raw.b[3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_resp_valid_o <= 1'b0;
            dm_resp_valid_o <= 1'b0;
        end else if (done_i) begin
            if_resp_valid_o <= !is_data_i;
            dm_resp_valid_o <= is_data_i;
        end else begin
            if (if_resp_valid_o && if_resp_ready_i) if_resp_valid_o <= 1'b0;
            if (dm_resp_valid_o && dm_resp_ready_i) dm_resp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done_i && is_data_i) begin
            dm_rdata_o <= masked.word;
        end
        if (done_i && !is_data_i) begin
            if_inst_o <= masked.word;
        end
    end

    // frees the request stage on the response handshake
    assign release_o = (if_resp_valid_o && if_resp_ready_i)
                    || (dm_resp_valid_o && dm_resp_ready_i);

    // a new result never lands on a response still waiting for its ready
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset_i)
        done_i |-> !(if_resp_valid_o || dm_resp_valid_o));

endmodule

`default_nettype wire

// ==== mem_ctrl_top.sv ====
// memory controller top level, joins request, sequencer, result stage and the byte ram
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_config.svh"

module mem_ctrl_top import mem_ctrl_pkg::*; (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     if_req_valid_i,
    output logic                    if_req_ready_o,
    input  wire [`MEM_ADDR_W-1:0]   if_addr_i,
    output logic                    if_resp_valid_o,
    input  wire                     if_resp_ready_i,
    output logic [31:0]             if_inst_o,
    input  wire                     dm_req_valid_i,
    output logic                    dm_req_ready_o,
    input  wire                     dm_we_i,
    input  wire mem_size_e          dm_size_i,
    input  wire [`MEM_ADDR_W-1:0]   dm_addr_i,
    input  wire [31:0]              dm_wdata_i,
    output logic                    dm_resp_valid_o,
    input  wire                     dm_resp_ready_i,
    output logic [31:0]             dm_rdata_o
);

    logic                   start;
    logic                   is_data;
    logic                   we;
    mem_size_e              size;
    logic [2:0]             nbytes;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    logic                   ram_we;
    logic [7:0]             ram_wdata;
    logic [7:0]             ram_rdata;
    logic                   done;
    logic [31:0]            load_word;
    logic                   resp_release;

    mem_req_decode i_mem_req_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .if_req_valid_i (if_req_valid_i),
        .if_req_ready_o (if_req_ready_o),
        .if_addr_i      (if_addr_i),
        .dm_req_valid_i (dm_req_valid_i),
        .dm_req_ready_o (dm_req_ready_o),
        .dm_we_i        (dm_we_i),
        .dm_size_i      (dm_size_i),
        .dm_addr_i      (dm_addr_i),
        .dm_wdata_i     (dm_wdata_i),
        .release_i      (resp_release),
        .start_o        (start),
        .is_data_o      (is_data),
        .we_o           (we),
        .size_o         (size),
        .nbytes_o       (nbytes),
        .addr_o         (addr),
        .wdata_o        (wdata)
    );

    mem_byte_sequencer i_mem_byte_sequencer (
        .clk         (clk),
        .reset_i     (reset_i),
        .start_i     (start),
        .we_i        (we),
        .nbytes_i    (nbytes),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata),
        .done_o      (done),
        .load_word_o (load_word)
    );

    mem_load_assemble i_mem_load_assemble (
        .clk             (clk),
        .reset_i         (reset_i),
        .done_i          (done),
        .is_data_i       (is_data),
        .we_i            (we),
        .size_i          (size),
        .load_word_i     (load_word),
        .release_o       (resp_release),
        .if_resp_valid_o (if_resp_valid_o),
        .if_resp_ready_i (if_resp_ready_i),
        .if_inst_o       (if_inst_o),
        .dm_resp_valid_o (dm_resp_valid_o),
        .dm_resp_ready_i (dm_resp_ready_i),
        .dm_rdata_o      (dm_rdata_o)
    );

    byte_ram i_byte_ram (
        .clk         (clk),
        .ram_addr_i  (ram_addr),
        .ram_we_i    (ram_we),
        .ram_wdata_i (ram_wdata),
        .ram_rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// free running clock source for the memory controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== tb_mem_ctrl.sv ====
// testbench for the memory controller, runs the cases file and then a random mix on both ports
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_config.svh"

module tb_mem_ctrl import mem_ctrl_pkg::*; ();

    localparam int          RAM_AW      = $clog2(`MEM_RAM_DEPTH);
    localparam logic [31:0] RAND_BASE   = 32'h300;
    localparam int          RAND_INIT   = 64;
    localparam int          RAND_OPS    = 200;
    localparam int          CASE_CYCLES = 64;
    localparam int          OP_CYCLES   = 16;

    logic        clk;
    logic        reset;
    logic        if_req_valid;
    logic        if_req_ready;
    logic [31:0] if_addr;
    logic        if_resp_valid;
    logic        if_resp_ready;
    logic [31:0] if_inst;
    logic        dm_req_valid;
    logic        dm_req_ready;
    logic        dm_we;
    mem_size_e   dm_size;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;
    logic        dm_resp_valid;
    logic        dm_resp_ready;
    logic [31:0] dm_rdata;

    string       case_name[$];
    string       case_port[$];
    bit          case_we[$];
    int          case_size[$];
    logic [31:0] case_addr[$];
    logic [31:0] case_wdata[$];
    logic [31:0] case_exp[$];

    logic [31:0] dm_resp_q[$];
    logic [31:0] if_resp_q[$];
    bit          order_q[$];
    logic [7:0]  shadow [`MEM_RAM_DEPTH];
    int          errors = 0;
    int          cases_ok = 0;
    int          cases_bad = 0;
    bit          cases_loaded = 1'b0;
    integer      seed = 32'h7422_1732;

    tb_clock_gen #(.PERIOD_NS(8)) i_tb_clock_gen (.clk_o(clk));

    mem_ctrl_top i_mem_ctrl_top (
        .clk             (clk),
        .reset_i         (reset),
        .if_req_valid_i  (if_req_valid),
        .if_req_ready_o  (if_req_ready),
        .if_addr_i       (if_addr),
        .if_resp_valid_o (if_resp_valid),
        .if_resp_ready_i (if_resp_ready),
        .if_inst_o       (if_inst),
        .dm_req_valid_i  (dm_req_valid),
        .dm_req_ready_o  (dm_req_ready),
        .dm_we_i         (dm_we),
        .dm_size_i       (dm_size),
        .dm_addr_i       (dm_addr),
        .dm_wdata_i      (dm_wdata),
        .dm_resp_valid_o (dm_resp_valid),
        .dm_resp_ready_i (dm_resp_ready),
        .dm_rdata_o      (dm_rdata)
    );

    // valid and ready seen together here means a transfer on the next edge
    always @(negedge clk) begin
        if (dm_resp_valid && dm_resp_ready) begin
            dm_resp_q.push_back(dm_rdata);
            order_q.push_back(1'b1);
        end
        if (if_resp_valid && if_resp_ready) begin
            if_resp_q.push_back(if_inst);
            order_q.push_back(1'b0);
        end
    end

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", label, expected, actual);
        end
    endtask

    function automatic int size_bytes(input int size);
        if (size == `MEM_SIZE_B) return 1;
        if (size == `MEM_SIZE_H) return 2;
        return 4;
    endfunction

    task automatic shadow_store(input logic [31:0] addr, input int size, input logic [31:0] wdata);
        for (int i = 0; i < size_bytes(size); i++) begin
            shadow[RAM_AW'(addr + 32'(i))] = wdata[8*i +: 8];
        end
    endtask

    // little-endian assembly, lanes above the size stay zero
    function automatic logic [31:0] shadow_load(input logic [31:0] addr, input int size);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < size_bytes(size); i++) begin
            value[8*i +: 8] = shadow[RAM_AW'(addr + 32'(i))];
        end
        return value;
    endfunction

    task automatic send_data(input bit we, input int size, input logic [31:0] addr,
                             input logic [31:0] wdata);
        @(posedge clk);
        dm_req_valid <= 1'b1;
        dm_we        <= we;
        dm_size      <= mem_size_e'(size);
        dm_addr      <= addr;
        dm_wdata     <= wdata;
        @(negedge clk);
        while (!dm_req_ready) @(negedge clk);
        @(posedge clk);
        dm_req_valid <= 1'b0;
    endtask

    task automatic send_fetch(input logic [31:0] addr);
        @(posedge clk);
        if_req_valid <= 1'b1;
        if_addr      <= addr;
        @(negedge clk);
        while (!if_req_ready) @(negedge clk);
        @(posedge clk);
        if_req_valid <= 1'b0;
    endtask

    task automatic wait_resp(input bit is_data, output logic [31:0] value);
        if (is_data) begin
            while (dm_resp_q.size() == 0) @(posedge clk);
            value = dm_resp_q.pop_front();
        end else begin
            while (if_resp_q.size() == 0) @(posedge clk);
            value = if_resp_q.pop_front();
        end
    endtask

    task automatic data_access(input string name, input bit we, input int size,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [31:0] expected);
        logic [31:0] got;
        send_data(we, size, addr, wdata);
        wait_resp(1'b1, got);
        check_value(name, expected, got);
    endtask

    task automatic fetch_access(input string name, input logic [31:0] addr,
                                input logic [31:0] expected);
        logic [31:0] got;
        send_fetch(addr);
        wait_resp(1'b0, got);
        check_value(name, expected, got);
    endtask

    // data and fetch raised on the same edge, data has to answer first
    task automatic both_access(input int k);
        logic [31:0] got_dm;
        logic [31:0] got_if;
        fork
            send_data(case_we[k], case_size[k], case_addr[k], case_wdata[k]);
            send_fetch(case_addr[k]);
        join
        wait_resp(1'b1, got_dm);
        wait_resp(1'b0, got_if);
        check_value({case_name[k], "/data"}, case_we[k] ? 32'd0 : case_exp[k], got_dm);
        check_value({case_name[k], "/fetch"}, case_exp[k], got_if);
        check_value({case_name[k], "/responses"}, 32'd2, 32'(order_q.size()));
        check_value({case_name[k], "/order"}, 32'd2, 32'({order_q[0], order_q[1]}));
    endtask

    task automatic stall_access(input int k);
        logic [31:0] held;
        logic [31:0] got;
        int          hold;
        @(posedge clk);
        dm_resp_ready <= 1'b0;
        send_data(case_we[k], case_size[k], case_addr[k], case_wdata[k]);
        @(negedge clk);
        while (!dm_resp_valid) @(negedge clk);
        held = dm_rdata;
        hold = 2 + ($unsigned($random(seed)) % 6);
        repeat (hold) begin
            @(negedge clk);
            check_value({case_name[k], "/valid"}, 32'd1, 32'(dm_resp_valid));
            check_value({case_name[k], "/held"}, held, dm_rdata);
            check_value({case_name[k], "/req_ready"}, 32'd0, 32'({dm_req_ready, if_req_ready}));
        end
        @(posedge clk);
        dm_resp_ready <= 1'b1;
        wait_resp(1'b1, got);
        check_value(case_name[k], case_exp[k], got);
    endtask

    task automatic report_case(input string name, input bit ok);
        if (ok) begin
            cases_ok++;
            $display("%-14s ok", name);
        end else begin
            cases_bad++;
            $display("%-14s FAILED", name);
        end
    endtask

    task automatic run_case(input int k);
        int errors_before;
        errors_before = errors;
        order_q.delete();
        if (case_port[k] == "fetch") begin
            fetch_access(case_name[k], case_addr[k], case_exp[k]);
        end else if (case_port[k] == "data") begin
            data_access(case_name[k], case_we[k], case_size[k], case_addr[k],
                        case_wdata[k], case_exp[k]);
        end else if (case_port[k] == "both") begin
            both_access(k);
        end else if (case_port[k] == "stall") begin
            stall_access(k);
        end else begin
            errors++;
            $display("case %s names an unknown port %s", case_name[k], case_port[k]);
        end
        report_case(case_name[k], errors == errors_before);
    endtask

    task automatic run_random();
        int          errors_before;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          size;
        errors_before = errors;
        // fill the region first so every later load has a known value
        for (int i = 0; i < RAND_INIT; i++) begin
            wdata = $random(seed);
            addr  = RAND_BASE + 32'(4 * i);
            data_access("random_init", 1'b1, `MEM_SIZE_W, addr, wdata, 32'd0);
            shadow_store(addr, `MEM_SIZE_W, wdata);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            r    = $random(seed);
            size = int'(r[2:1]) % 3;
            addr = RAND_BASE + (32'(r[15:8]) % 32'd253);
            if (r[0]) begin
                wdata = $random(seed);
                data_access("random_store", 1'b1, size, addr, wdata, 32'd0);
                shadow_store(addr, size, wdata);
            end else if (size == `MEM_SIZE_W && r[3]) begin
                fetch_access("random_fetch", addr, shadow_load(addr, size));
            end else begin
                data_access("random_load", 1'b0, size, addr, 32'd0, shadow_load(addr, size));
            end
        end
        report_case("random_mix", errors == errors_before);
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        int          we;
        int          size;
        string       line;
        string       name;
        string       port;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        fd = $fopen("mem_ctrl_cases.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %s %d %d %h %h %h", name, port, we, size, addr, wdata,
                            expected);
                if (n == 7) begin
                    case_name.push_back(name);
                    case_port.push_back(port);
                    case_we.push_back(we != 0);
                    case_size.push_back(size);
                    case_addr.push_back(addr);
                    case_wdata.push_back(wdata);
                    case_exp.push_back(expected);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        check_value("reset/dm_req_ready", 32'd1, 32'(dm_req_ready));
        check_value("reset/if_req_ready", 32'd1, 32'(if_req_ready));
        check_value("reset/resp_valid", 32'd0, 32'({dm_resp_valid, if_resp_valid}));
        report_case("reset_state", errors == errors_before);
    endtask

    initial begin
        int limit;
        wait (cases_loaded);
        limit = case_name.size() * CASE_CYCLES + (RAND_INIT + RAND_OPS) * OP_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        if_req_valid  = 1'b0;
        if_addr       = '0;
        if_resp_ready = 1'b1;
        dm_req_valid  = 1'b0;
        dm_we         = 1'b0;
        dm_size       = MEM_SIZE_BYTE;
        dm_addr       = '0;
        dm_wdata      = '0;
        dm_resp_ready = 1'b1;
        load_cases();
        if (case_name.size() == 0) begin
            $display("no cases could be read from mem_ctrl_cases.txt");
            $display("test failed");
            $finish;
        end else begin
            cases_loaded = 1'b1;
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            check_reset_state();
            for (int k = 0; k < case_name.size(); k++) begin
                run_case(k);
            end
            run_random();
            $display("summary: %0d cases ok, %0d cases failed, %0d mismatches",
                     cases_ok, cases_bad, errors);
            if (errors == 0 && cases_bad == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== mem_ctrl_cases.txt ====
# name port we size addr wdata expected, values in hex, size 0 byte 1 half 2 word
# port fetch, data, both (data and fetch of one address together), stall (data, held response)
w_store      data  1 2 00000010 deadbeef 00000000
w_load       data  0 2 00000010 00000000 deadbeef
w_fetch      fetch 0 2 00000010 00000000 deadbeef
b_store      data  1 0 00000011 000000a5 00000000
h_store      data  1 1 00000012 00001234 00000000
merge_load   data  0 2 00000010 00000000 1234a5ef
b_load_hi    data  0 0 00000013 00000000 00000012
b_load_lo    data  0 0 00000010 00000000 000000ef
h_load       data  0 1 00000011 00000000 000034a5
w_store_sgn  data  1 2 00000020 80ff7f81 00000000
b_load_sgn   data  0 0 00000023 00000000 00000080
h_load_sgn   data  0 1 00000022 00000000 000080ff
b_load_7f    data  0 0 00000021 00000000 0000007f
both_store   both  1 2 00000030 cafef00d cafef00d
both_load    both  0 2 00000010 00000000 1234a5ef
stall_load   stall 0 2 00000020 00000000 80ff7f81
stall_store  stall 1 1 00000022 0000beef 00000000
stall_merge  data  0 2 00000020 00000000 beef7f81
stall_byte   stall 0 0 00000031 00000000 000000f0
wrap_fetch   fetch 0 2 00001010 00000000 1234a5ef
wrap_store   data  1 0 00000433 00000077 00000000
wrap_check   fetch 0 2 00000030 00000000 77fef00d

// ==== flist.f ====
+incdir+.
mem_ctrl_pkg.sv
byte_ram.sv
mem_req_decode.sv
mem_byte_sequencer.sv
mem_load_assemble.sv
mem_ctrl_top.sv
tb_clock_gen.sv
tb_mem_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the memory controller testbench with verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mem_ctrl -f flist.f -o sim_mem_ctrl
./obj_dir/sim_mem_ctrl | tee sim.log

if grep -q "test passed" sim.log; then
    echo "PASS: memory controller simulation"
    exit 0
fi

echo "FAIL: memory controller simulation, see sim.log"
exit 1
